/* uart_stim.txt */
# op addr data expected pslverr, values in hex
# W write, R read and compare, S wait for idle and compare bytes, N wait data frames
R 04 00 20 0
R 08 00 00 0
W 04 55 00 1
W 0c 55 00 1
R 00 00 00 1
R 10 00 00 1
R 04 00 20 0
W 00 a5 00 0
W 00 3c 00 0
W 00 f0 00 0
R 04 00 03 0
N 00 01 00 0
W 08 01 00 0
R 08 00 01 0
S 00 00 00 0
W 08 00 00 0
W 00 01 00 0
W 00 80 00 0
W 00 ff 00 0
W 00 00 00 0
W 00 5a 00 0
W 00 c3 00 0
W 00 7e 00 0
W 00 96 00 0
W 00 11 00 1
R 04 00 48 0
W 08 01 00 0
S 00 00 00 0
W 00 e7 00 0
R 04 00 a0 0
S 00 00 00 0

/* files.f */
uart_pkg.sv
apb_pkg.sv
apb_uart_regs.sv
tx_fifo.sv
uart_tx.sv
uart_top.sv
tb_clock_gen.sv
tb_uart_assertions.sv
tb_uart.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --assert -Wno-fatal --top-module tb_uart -f files.f -o sim_uart \
        > build.log 2>&1 \
    && ./obj_dir/sim_uart +verilator+error+limit+1000 > sim.log 2>&1 \
    && ! grep -q "Done: errors found" sim.log \
    && grep -q "Done: no errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* tb_uart.sv */
`timescale 1ns/1ps

module tb_uart;

    localparam int FRAME_CYCLES = uart_pkg::TICKS_PER_BIT * 10;   // start, 8 data, stop

    logic              clk;
    logic              rst_n;
    apb_pkg::apb_req_t apb_req;
    apb_pkg::apb_rsp_t apb_rsp;
    logic              txd;
    logic [7:0]        exp_q [$];                       // bytes accepted over apb
    logic [7:0]        rx_q [$];                        // bytes decoded from the line
    int                stim_lines = 0;
    int                mismatches = 0;
    int                failures   = 0;

    tb_clock_gen u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    uart_top DUT (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_apb   (apb_req),
        .o_apb   (apb_rsp),
        .o_txd   (txd)
    );

    bind uart_top tb_uart_assertions u_assertions (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_apb   (i_apb),
        .i_rsp   (o_apb),
        .i_txd   (o_txd),
        .i_busy  (busy),
        .i_push  (push),
        .i_pop   (pop),
        .i_full  (full),
        .i_empty (empty)
    );

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH time %0d ns %s expected %02h actual %02h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH time %0d ns %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_status(input uart_pkg::uart_status_t exp,
                                input uart_pkg::uart_status_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH time %0d ns STATUS expected %02h actual %02h", $time, exp, act);
        end
    endtask

    task automatic check_rsp(input string name, input apb_pkg::apb_rsp_t exp,
                             input apb_pkg::apb_rsp_t act);
        if (act.prdata !== exp.prdata || act.pslverr !== exp.pslverr) begin
            mismatches++;
            $display("MISMATCH time %0d ns %s prdata/pslverr expected %08h/%b actual %08h/%b",
                     $time, name, exp.prdata, exp.pslverr, act.prdata, act.pslverr);
        end
    endtask

    // setup then access phase with the response sampled mid access cycle
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output apb_pkg::apb_rsp_t rsp);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1 apb_req.penable = 1'b1;
        @(negedge clk);
        rsp = apb_rsp;
        @(posedge clk);
        #1 apb_req = '0;
    endtask

    // poll STATUS until empty and not busy, then compare the byte queues
    task automatic drain_and_compare();
        apb_pkg::apb_rsp_t      rsp;
        uart_pkg::uart_status_t st;
        int                     polls;
        polls = 0;
        do begin
            repeat (uart_pkg::TICKS_PER_BIT) @(posedge clk);
            apb_xfer(1'b0, apb_pkg::STATUS, 32'h0, rsp);
            st = uart_pkg::uart_status_t'(rsp.prdata[7:0]);
            polls++;
        end while ((st.busy || !st.empty) && polls < 200);
        check_status(uart_pkg::uart_status_t'(8'h20), st);
        if (rx_q.size() != exp_q.size()) begin
            failures++;
            $display("received %0d bytes on the line but %0d were accepted",
                     rx_q.size(), exp_q.size());
        end
        while (exp_q.size() > 0 && rx_q.size() > 0) begin
            check_byte("o_txd byte", exp_q.pop_front(), rx_q.pop_front());
        end
        exp_q.delete();
        rx_q.delete();
    endtask

    // serial line decoder sampling each bit at its middle
    initial begin : line_decoder
        logic [7:0] rx;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge txd);
            repeat (uart_pkg::TICKS_PER_BIT / 2) @(negedge clk);
            if (txd !== 1'b0) begin
                failures++;
                $display("start bit at time %0d ns did not hold low", $time);
            end
            for (int i = 0; i < 8; i++) begin
                repeat (uart_pkg::TICKS_PER_BIT) @(negedge clk);
                rx[i] = txd;                            // lsb first
            end
            repeat (uart_pkg::TICKS_PER_BIT) @(negedge clk);
            if (txd !== 1'b1) begin
                failures++;
                $display("framing error, stop bit low at time %0d ns", $time);
            end
            rx_q.push_back(rx);
        end
    end

    initial begin : watchdog
        wait (stim_lines > 0);
        #(longint'(stim_lines) * 11 * FRAME_CYCLES * 8 + 20000);
        $display("timeout, the stimulus did not finish in the allowed time");
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, DUT.u_assertions.fail_count);
        $display("Done: errors found");
        $finish;
    end

    initial begin : stimulus
        int                fd;
        string             line;
        string             op;
        string             stim_q [$];
        logic [31:0]       addr;
        logic [31:0]       data;
        logic [31:0]       exp;
        logic [31:0]       err;
        apb_pkg::apb_rsp_t rsp;
        apb_pkg::apb_rsp_t exp_rsp;
        apb_req = '0;
        fd = $fopen("uart_stim.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("could not open uart_stim.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") stim_q.push_back(line);
            end
            $fclose(fd);
        end
        stim_lines = stim_q.size();
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_bit("o_txd", 1'b1, txd);                  // idle line after reset
        foreach (stim_q[i]) begin
            if ($sscanf(stim_q[i], "%s %h %h %h %h", op, addr, data, exp, err) != 5) begin
                failures++;
                $display("stim line %0d could not be parsed", i);
                continue;
            end
            exp_rsp.prdata  = (op == "R") ? exp : 32'h0;
            exp_rsp.pslverr = err[0];
            case (op)
                "W": begin
                    apb_xfer(1'b1, addr[7:0], data, rsp);
                    check_rsp($sformatf("write %02h", addr[7:0]), exp_rsp, rsp);
                    if (addr[7:0] == apb_pkg::DATA && !err[0]) exp_q.push_back(data[7:0]);
                end
                "R": begin
                    apb_xfer(1'b0, addr[7:0], 32'h0, rsp);
                    check_rsp($sformatf("read %02h", addr[7:0]), exp_rsp, rsp);
                    if (addr[7:0] == apb_pkg::STATUS) begin
                        check_status(uart_pkg::uart_status_t'(exp[7:0]),
                                     uart_pkg::uart_status_t'(rsp.prdata[7:0]));
                    end
                end
                "S": drain_and_compare();
                "N": repeat (data * FRAME_CYCLES) @(posedge clk);
                default: begin
                    failures++;
                    $display("unknown operation %s in stim line %0d", op, i);
                end
            endcase
        end
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, DUT.u_assertions.fail_count);
        if (mismatches + failures + DUT.u_assertions.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* tb_uart_assertions.sv */
`timescale 1ns/1ps

module tb_uart_assertions (
    input logic              i_clk,
    input logic              i_rst_n,
    input apb_pkg::apb_req_t i_apb,
    input apb_pkg::apb_rsp_t i_rsp,
    input logic              i_txd,
    input logic              i_busy,
    input logic              i_push,
    input logic              i_pop,
    input logic              i_full,
    input logic              i_empty
);

    int   fail_count = 0;                               // read by tb_uart at the end
    logic access;

    assign access = i_apb.psel && i_apb.penable;

    a_txd_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n) !i_busy |-> i_txd)
        else begin
            fail_count++;
            $error("line is low while the serializer is idle");
        end

    a_pready: assert property (@(posedge i_clk) disable iff (!i_rst_n) access |-> i_rsp.pready)
        else begin
            fail_count++;
            $error("pready low during an access phase");
        end

    a_pslverr: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_rsp.pslverr |-> access)
        else begin
            fail_count++;
            $error("pslverr high outside an access phase");
        end

    a_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_push |-> !i_full)
        else begin
            fail_count++;
            $error("push issued while the fifo is full");
        end

    a_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_pop |-> !i_empty)
        else begin
            fail_count++;
            $error("pop issued while the fifo is empty");
        end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;                      // 8 ns period
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (10) @(posedge o_clk);                   // held for 10 cycles
        #1 o_rst_n = 1'b1;
    end

endmodule

/* uart_top.sv */
`timescale 1ns/1ps

module uart_top (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  apb_pkg::apb_req_t i_apb,
    output apb_pkg::apb_rsp_t o_apb,
    output logic              o_txd
);

    logic             push;
    logic [7:0]       push_data;
    logic             pop;
    logic [7:0]       head;
    logic             full;
    logic             empty;
    uart_pkg::level_t level;
    logic             busy;
    logic             enable;

    // bus side
    apb_uart_regs u_regs (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_apb       (i_apb),
        .o_apb       (o_apb),
        .o_push      (push),
        .o_push_data (push_data),
        .i_full      (full),
        .i_empty     (empty),
        .i_level     (level),
        .i_busy      (busy),
        .o_enable    (enable)
    );

    tx_fifo u_fifo (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_push      (push),
        .i_push_data (push_data),
        .i_pop       (pop),
        .o_head      (head),
        .o_full      (full),
        .o_empty     (empty),
        .o_level     (level)
    );

    // line side
    uart_tx u_tx (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_enable (enable),
        .i_empty  (empty),
        .i_head   (head),
        .o_pop    (pop),
        .o_busy   (busy),
        .o_txd    (o_txd)
    );

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_enable,
    input  logic       i_empty,
    input  logic [7:0] i_head,
    output logic       o_pop,
    output logic       o_busy,
    output logic       o_txd
);

    uart_pkg::tx_state_e         state;
    uart_pkg::tx_state_e         next_state;
    logic [uart_pkg::TICK_W-1:0] tick_cnt;
    logic [2:0]                  bit_cnt;               // data bit index
    logic [7:0]                  shift_reg;
    logic                        tick_last;
    logic                        in_frame;              // a bit is on the line

    assign tick_last = tick_cnt == uart_pkg::TICK_W'(uart_pkg::TICKS_PER_BIT - 1);
    assign in_frame  = (state == uart_pkg::START) ||
                       (state == uart_pkg::DATA)  ||
                       (state == uart_pkg::STOP);

    // frame starts on its own once enabled and data is waiting
    assign o_pop  = (state == uart_pkg::IDLE) && i_enable && !i_empty;
    assign o_busy = state != uart_pkg::IDLE;

    always_comb begin
        next_state = state;
        o_txd      = 1'b1;                              // idle line
        case (state)
            uart_pkg::IDLE: begin
                if (o_pop) begin
                    next_state = uart_pkg::START;
                end
            end
            uart_pkg::START: begin
                o_txd = 1'b0;
                if (tick_last) begin
                    next_state = uart_pkg::DATA;
                end
            end
            uart_pkg::DATA: begin
                o_txd = shift_reg[0];                   // lsb first
                if (tick_last && bit_cnt == 3'd7) begin
                    next_state = uart_pkg::STOP;
                end
            end
            uart_pkg::STOP: begin
                if (tick_last) begin
                    next_state = uart_pkg::DONE;
                end
            end
            uart_pkg::DONE: begin
                next_state = uart_pkg::IDLE;            // one cycle gap
            end
            default: next_state = uart_pkg::IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= uart_pkg::IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            state <= next_state;
            if (in_frame && !tick_last) begin
                tick_cnt <= tick_cnt + 1'b1;
            end else begin
                tick_cnt <= '0;                         // restart for each bit
            end
            if (state == uart_pkg::IDLE) begin
                bit_cnt <= '0;
            end else if (state == uart_pkg::DATA && tick_last) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // byte is loaded at the pop edge, shifted after each data bit
    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            shift_reg <= i_head;
        end else if (state == uart_pkg::DATA && tick_last) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

/* tx_fifo.sv */
`timescale 1ns/1ps

module tx_fifo (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_push,
    input  logic [7:0]       i_push_data,
    input  logic             i_pop,
    output logic [7:0]       o_head,
    output logic             o_full,
    output logic             o_empty,
    output uart_pkg::level_t o_level
);

    logic [7:0]                      mem [uart_pkg::FIFO_DEPTH];
    logic [uart_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [uart_pkg::FIFO_PTR_W-1:0] rd_ptr;
    uart_pkg::level_t                count;

    assign o_head  = mem[rd_ptr];                       // head byte seen before the pop
    assign o_full  = count == uart_pkg::level_t'(uart_pkg::FIFO_DEPTH);
    assign o_empty = count == '0;
    assign o_level = count;

    // storage, written on push
    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // both or neither
            endcase
        end
    end

endmodule

/* apb_uart_regs.sv */
`timescale 1ns/1ps

module apb_uart_regs (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  apb_pkg::apb_req_t     i_apb,
    output apb_pkg::apb_rsp_t     o_apb,
    output logic                  o_push,
    output logic [7:0]            o_push_data,
    input  logic                  i_full,
    input  logic                  i_empty,
    input  uart_pkg::level_t      i_level,
    input  logic                  i_busy,
    output logic                  o_enable
);

    logic                   access;                     // apb access phase
    logic                   room;                       // fifo can take a byte
    logic                   ctrl_we;
    uart_pkg::uart_status_t status;
    apb_pkg::apb_rsp_t      rsp;

    assign access = i_apb.psel & i_apb.penable;
    assign room   = i_level < uart_pkg::level_t'(uart_pkg::FIFO_DEPTH);

    assign status.busy  = i_busy;
    assign status.full  = i_full;
    assign status.empty = i_empty;
    assign status.rsvd  = 1'b0;
    assign status.level = i_level;

    assign o_push_data = i_apb.pwdata[7:0];

    // the transfer completes in the access cycle, so decode is combinational
    always_comb begin
        o_push      = 1'b0;
        ctrl_we     = 1'b0;
        rsp.prdata  = '0;
        rsp.pready  = 1'b1;                             // no wait states
        rsp.pslverr = 1'b0;
        if (access) begin
            case (i_apb.paddr)
                apb_pkg::DATA: begin
                    if (i_apb.pwrite && room) begin
                        o_push = 1'b1;
                    end else begin
                        rsp.pslverr = 1'b1;             // fifo full or read of DATA
                    end
                end
                apb_pkg::STATUS: begin
                    if (i_apb.pwrite) begin
                        rsp.pslverr = 1'b1;
                    end else begin
                        rsp.prdata = {24'b0, status};
                    end
                end
                apb_pkg::CTRL: begin
                    if (i_apb.pwrite) begin
                        ctrl_we = 1'b1;
                    end else begin
                        rsp.prdata = {31'b0, o_enable};
                    end
                end
                default: rsp.pslverr = 1'b1;            // unmapped
            endcase
        end
    end

    assign o_apb = rsp;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_enable <= 1'b0;
        end else if (ctrl_we) begin
            o_enable <= i_apb.pwdata[0];
        end
    end

endmodule

/* apb_pkg.sv */
package apb_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // master to slave
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    // slave to master
    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // register map
    typedef enum logic [ADDR_W-1:0] {
        DATA   = 8'h00,                                 // write only, pushes a byte
        STATUS = 8'h04,                                 // read only
        CTRL   = 8'h08                                  // bit 0 is transmit enable
    } reg_addr_e;

endpackage

/* uart_pkg.sv */
package uart_pkg;

    localparam int TICKS_PER_BIT = 16;                  // clock cycles per serial bit
    localparam int TICK_W        = $clog2(TICKS_PER_BIT);
    localparam int FIFO_DEPTH    = 8;                   // transmit FIFO entries
    localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);

    typedef logic [3:0] level_t;                        // holds 0 to FIFO_DEPTH

    typedef enum logic [2:0] {
        IDLE,                                           // line high, waiting for data
        START,                                          // start bit, line low
        DATA,                                           // eight data bits, lsb first
        STOP,                                           // stop bit, line high
        DONE                                            // one cycle gap before idle
    } tx_state_e;

    // read value of the STATUS register, bit 4 reads as zero
    typedef struct packed {
        logic   busy;                                   // bit 7
        logic   full;                                   // bit 6
        logic   empty;                                  // bit 5
        logic   rsvd;                                   // bit 4
        level_t level;                                  // bits 3:0
    } uart_status_t;

endpackage
